// File: source/bus_pkg.sv
package bus_pkg;

    typedef logic [31:0] addr_t;      // byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;      // one enable per byte lane
    typedef logic [7:0]  ram_index_t; // scratch RAM word index
    typedef logic [1:0]  resp_code_t;
    typedef logic [1:0]  route_t;

    localparam resp_code_t RESP_OKAY   = 2'd0;
    localparam resp_code_t RESP_DECERR = 2'd3;

    localparam route_t ROUTE_RAM  = 2'd0;
    localparam route_t ROUTE_LED  = 2'd1;
    localparam route_t ROUTE_NONE = 2'd2;

    // region map, inclusive bounds
    localparam addr_t RAM_START = 32'h0000_0000;
    localparam addr_t RAM_END   = 32'h0FFF_FFFF;
    localparam addr_t LED_START = 32'h2000_0000;
    localparam addr_t LED_END   = 32'h2FFF_FF0F;

    localparam int RAM_DEPTH = 256;
    localparam int LED_WIDTH = 8;

    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
        strb_t strb;
    } bus_req_t;

    typedef struct packed {
        logic       write;
        ram_index_t index;
        data_t      wdata;
        strb_t      strb;
    } slave_req_t;

    typedef struct packed {
        resp_code_t resp;
        data_t      rdata;
    } bus_rsp_t;

    function automatic logic addr_in_region(input addr_t addr, input addr_t lo, input addr_t hi);
        return (addr >= lo) && (addr <= hi);
    endfunction

    // replace only the byte lanes with strb set
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t word;
        word = old_word;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return word;
    endfunction

endpackage

// File: source/bus_addr_decode.sv
module bus_addr_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  bus_pkg::bus_req_t   req,
    output bus_pkg::slave_req_t slave_req,
    output logic                ram_sel,
    output logic                led_sel,
    output logic                route_valid,
    output bus_pkg::route_t     route
);
    import bus_pkg::*;

    logic       hit_ram;
    logic       hit_led;
    route_t     route_next;
    ram_index_t index_next;

    always_comb begin
        hit_ram = addr_in_region(req.addr, RAM_START, RAM_END);
        hit_led = addr_in_region(req.addr, LED_START, LED_END);
    end

    always_comb begin
        if (hit_ram) begin
            route_next = ROUTE_RAM;
        end else if (hit_led) begin
            route_next = ROUTE_LED;
        end else begin
            route_next = ROUTE_NONE; // answered by the merger with an error
        end
    end

    // word index from addr bits 9:2, so the RAM repeats across region 0
    assign index_next = ram_index_t'(req.addr >> 2);

    // strobes and tag valid, one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram_sel     <= 1'b0;
            led_sel     <= 1'b0;
            route_valid <= 1'b0;
        end else begin
            ram_sel     <= req_valid && hit_ram;
            led_sel     <= req_valid && hit_led;
            route_valid <= req_valid;  // every request gets a tag
        end
    end

    // payload only moves on a request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            slave_req.write <= req.write;
            slave_req.index <= index_next;
            slave_req.wdata <= req.wdata;
            slave_req.strb  <= req.strb;
            route           <= route_next;
        end
    end

endmodule

// File: source/scratch_ram_slave.sv
module scratch_ram_slave (
    input  logic                clk,
    input  logic                sel,
    input  bus_pkg::slave_req_t slave_req,
    output bus_pkg::data_t      rdata
);
    import bus_pkg::*;

    data_t mem [RAM_DEPTH];

    // write merges strobed bytes, read gives the word one cycle later
    always_ff @(posedge clk) begin
        if (sel) begin
            if (slave_req.write) begin
                mem[slave_req.index] <= merge_bytes(mem[slave_req.index], slave_req.wdata,
                                                    slave_req.strb);
            end else begin
                rdata <= mem[slave_req.index];
            end
        end
    end

endmodule

// File: source/led_reg_slave.sv
module led_reg_slave (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            sel,
    input  bus_pkg::slave_req_t             slave_req,
    output bus_pkg::data_t                  rdata,
    output logic [bus_pkg::LED_WIDTH-1:0]   led
);
    import bus_pkg::*;

    data_t led_reg;

    // full 32 bits are kept, only the low bits reach the pins
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led_reg <= '0;
        end else if (sel && slave_req.write) begin
            led_reg <= merge_bytes(led_reg, slave_req.wdata, slave_req.strb);
        end
    end

    always_ff @(posedge clk) begin
        if (sel && !slave_req.write) begin
            rdata <= led_reg;   // read-back
        end
    end

    assign led = led_reg[LED_WIDTH-1:0];

endmodule

// File: source/bus_resp_mux.sv
module bus_resp_mux (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              route_valid,
    input  bus_pkg::route_t   route,
    input  logic              write,
    input  bus_pkg::data_t    ram_rdata,
    input  bus_pkg::data_t    led_rdata,
    output logic              rsp_valid,
    output bus_pkg::bus_rsp_t rsp
);
    import bus_pkg::*;

    // tag waits one stage for the slave read data
    typedef struct packed {
        logic   write;
        route_t route;
    } tag_t;

    logic     tag_valid;
    tag_t     tag;
    bus_rsp_t rsp_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= route_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (route_valid) begin
            tag.write <= write;
            tag.route <= route;
        end
    end

    always_comb begin
        rsp_next.resp  = RESP_OKAY;
        rsp_next.rdata = '0;        // writes return zero data
        case (tag.route)
            ROUTE_RAM: begin
                if (!tag.write) begin
                    rsp_next.rdata = ram_rdata;
                end
            end
            ROUTE_LED: begin
                if (!tag.write) begin
                    rsp_next.rdata = led_rdata;
                end
            end
            default: begin
                rsp_next.resp = RESP_DECERR; // unmapped address
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= tag_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_valid) begin
            rsp <= rsp_next;
        end
    end

endmodule

// File: source/bus_top.sv
module bus_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  bus_pkg::bus_req_t             req,
    output logic                          rsp_valid,
    output bus_pkg::bus_rsp_t             rsp,
    output logic [bus_pkg::LED_WIDTH-1:0] led
);
    import bus_pkg::*;

    slave_req_t slave_req;
    logic       ram_sel;
    logic       led_sel;
    logic       route_valid;
    route_t     route;
    data_t      ram_rdata;
    data_t      led_rdata;

    bus_addr_decode decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .slave_req   (slave_req),
        .ram_sel     (ram_sel),
        .led_sel     (led_sel),
        .route_valid (route_valid),
        .route       (route)
    );

    // region 0
    scratch_ram_slave ram_i (
        .clk       (clk),
        .sel       (ram_sel),
        .slave_req (slave_req),
        .rdata     (ram_rdata)
    );

    // region 2
    led_reg_slave led_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (led_sel),
        .slave_req (slave_req),
        .rdata     (led_rdata),
        .led       (led)
    );

    bus_resp_mux resp_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .route_valid (route_valid),
        .route       (route),
        .write       (slave_req.write),
        .ram_rdata   (ram_rdata),
        .led_rdata   (led_rdata),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

endmodule

// File: bench/tb_bus_model.svh
// expected storage, updated as each request is issued
data_t       model_ram [256];
data_t       model_led = '0;
logic [31:0] lfsr_state = 32'ha40b;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

// one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

function automatic data_t apply_strobes(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
endfunction

// initial RAM contents, every address bit counts
function automatic data_t fill_word(input addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
endfunction

// expected response of one request
function automatic bus_rsp_t bus_model(input bus_req_t r);
    bus_rsp_t   rsp;
    logic [7:0] idx;
    rsp.resp  = RESP_OKAY;
    rsp.rdata = '0;
    idx       = r.addr[9:2];
    if (r.addr[31:28] == 4'h0) begin   // region 0, repeats every 1 KiB
        if (r.write) begin
            model_ram[idx] = apply_strobes(model_ram[idx], r.wdata, r.strb);
        end else begin
            rsp.rdata = model_ram[idx];
        end
    end else if (r.addr >= 32'h2000_0000 && r.addr <= 32'h2FFF_FF0F) begin
        if (r.write) begin
            model_led = apply_strobes(model_led, r.wdata, r.strb);
        end else begin
            rsp.rdata = model_led;
        end
    end else begin
        rsp.resp = RESP_DECERR;         // storage untouched
    end
    return rsp;
endfunction

// File: bench/tb_bus_top.sv
module tb_bus_top;
    import bus_pkg::*;

    localparam int N_WORDS  = 256;
    localparam int N_LED    = 6;
    localparam int N_ERR    = 13;   // 4 write/read pairs plus 5 read-backs
    localparam int N_RANDOM = 500;
    localparam int TOTAL_REQS     = 3 * N_WORDS + 2 * N_LED + N_ERR + N_RANDOM;
    localparam int TIMEOUT_CYCLES = 10 + 2 * TOTAL_REQS + 50;

    typedef struct packed {
        bus_rsp_t    rsp;
        logic [31:0] due;   // cycle_cnt when rsp_valid is expected
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    bus_req_t    req;
    logic        rsp_valid;
    bus_rsp_t    rsp;
    logic [7:0]  led;
    logic [31:0] cycle_cnt = '0;
    expect_t     exp_q [$];

    `include "tb_bus_model.svh"

    bus_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .led       (led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, want));
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 32'd1;
        if (cycle_cnt >= 32'(TIMEOUT_CYCLES)) begin
            abort_run("the run timed out before all responses came back");
        end
    end

    // compare each response with the oldest expected one
    always @(negedge clk) begin : compare
        expect_t head;
        if (rsp_valid === 1'b1) begin
            assert (exp_q.size() > 0) else abort_run("rsp_valid raised with no request pending");
            head = exp_q.pop_front();
            assert (head.due == cycle_cnt) else report_mismatch("rsp cycle", cycle_cnt, head.due);
            assert (rsp.resp === head.rsp.resp)
                else report_mismatch("rsp.resp", {30'h0, rsp.resp}, {30'h0, head.rsp.resp});
            assert (rsp.rdata === head.rsp.rdata)
                else report_mismatch("rsp.rdata", rsp.rdata, head.rsp.rdata);
        end else if (exp_q.size() > 0) begin
            assert (exp_q[0].due != cycle_cnt) else abort_run("a response did not arrive in time");
        end
    end

    function automatic bus_req_t make_req(input logic write, input addr_t addr,
                                          input data_t wdata, input strb_t strb);
        bus_req_t r;
        r.write = write;
        r.addr  = addr;
        r.wdata = wdata;
        r.strb  = strb;
        return r;
    endfunction

    // random upper bits so region 0 aliases land on the same word
    function automatic addr_t ram_addr(input ram_index_t idx);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand_bits(18);
        lo = rand_bits(2);
        return {4'h0, hi[17:0], idx, lo[1:0]};
    endfunction

    // issue one request and queue its expected response
    task automatic send(input bus_req_t r);
        expect_t e;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        e.rsp = bus_model(r);
        e.due = cycle_cnt + 32'd4;  // request cycle is cycle_cnt + 1, answer 3 cycles on
        exp_q.push_back(e);
    endtask

    task automatic send_random(input logic write, input addr_t addr);
        data_t       d;
        logic [31:0] s;
        d = rand_bits(32);
        s = rand_bits(4);
        send(make_req(write, addr, d, s[3:0]));
    endtask

    task automatic pause(input int n);
        repeat (n) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_idle();
        assert (rsp_valid === 1'b0) else abort_run("rsp_valid raised with no request issued");
        assert (led === 8'h00) else report_mismatch("led", {24'h0, led}, 32'h0);
    endtask

    task automatic check_led();
        assert (led === model_led[7:0])
            else report_mismatch("led", {24'h0, led}, {24'h0, model_led[7:0]});
    endtask

    initial begin
        addr_t       a;
        addr_t       err_addr [4];
        logic [31:0] v;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (10) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end

        // scratch RAM fill then strobed writes then aliased reads
        for (int i = 0; i < N_WORDS; i++) begin
            a = addr_t'(i) << 2;
            send(make_req(1'b1, a, fill_word(a), 4'hf));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            send_random(1'b1, ram_addr(ram_index_t'(i)));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            send_random(1'b0, ram_addr(ram_index_t'(i)));
        end
        pause(1);
        drain();

        // LED register
        for (int i = 0; i < N_LED; i++) begin
            v = rand_bits(24);
            send_random(1'b1, {4'h2, v[19:0], 4'h0, v[23:20]});
            pause(1);
            drain();
            check_led();
            v = rand_bits(24);
            send_random(1'b0, {4'h2, v[19:0], 4'h0, v[23:20]});
        end
        pause(1);
        drain();

        // unmapped addresses and a read-back of what they alias
        v = rand_bits(32);
        err_addr[0] = {4'h1, v[27:0]};
        v = rand_bits(32);
        err_addr[1] = {4'h3, v[27:0]};
        v = rand_bits(8);
        err_addr[2] = {24'h2F_FFFF, v[3:0] | 4'h1, v[7:4]};
        err_addr[3] = 32'h2FFF_FF10;    // first address past the LED region
        for (int i = 0; i < 4; i++) begin
            send_random(1'b1, err_addr[i]);
            send_random(1'b0, err_addr[i]);
        end
        for (int i = 0; i < 4; i++) begin
            send_random(1'b0, ram_addr(err_addr[i][9:2]));
        end
        send_random(1'b0, 32'h2000_0000);
        pause(1);
        drain();
        check_led();

        // random traffic with gaps
        for (int n = 0; n < N_RANDOM; n++) begin
            v = rand_bits(2);
            if (v[1:0] == 2'd0) begin
                pause(1);
            end
            v = rand_bits(3);
            a = rand_bits(32);
            case (v[1:0])
                2'd1:    a = {4'h2, a[27:0]};
                2'd2:    a = {a[31:30], 2'b01, a[27:0]};  // regions 1, 5, 9 and 13
                default: a = {4'h0, a[27:0]};
            endcase
            send_random(v[2], a);
        end
        pause(1);
        drain();
        check_led();
        repeat (4) @(negedge clk);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+bench
source/bus_pkg.sv
source/bus_addr_decode.sv
source/scratch_ram_slave.sv
source/led_reg_slave.sv
source/bus_resp_mux.sv
source/bus_top.sv
bench/tb_bus_top.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_bus_top
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

$(OBJ_DIR)/$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
